// ==== build.f ====
hw/legv8_pkg.sv
hw/alu.sv
hw/forwarding_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_writeback.sv
hw/legv8_core.sv
sim/tb_legv8_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the build directory and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_legv8_core \
		--Mdir obj_dir -o vsim
	./obj_dir/vsim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "Test failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then echo "Run ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== sim/legv8_vectors.txt ====
# P <instruction word, hex> <assembly, not read>
# S <test name> <store address, hex> <store data, hex> <note, not read>
P 8B020029 ADD  X9, X1, X2
P AA04012A ORR  X10, X9, X4
P F800000A STUR X10, [X0, #0]
S st_orr_mem_fwd 0 7 3 | 4
P 8A0600EB AND  X11, X7, X6
P CB0B028C SUB  X12, X20, X11
P F800202C STUR X12, [X1, #2]
S st_sub_mem_fwd 3 E 20 - 6
P F8001069 STUR X9, [X3, #1]
S st_add_regfile 4 3 1 + 2
P F840304D LDUR X13, [X2, #3]
P 8B0501AE ADD  X14, X13, X5
P F800408E STUR X14, [X4, #4]
S st_load_use 8 1E 25 + 5
P CB0C01CF SUB  X15, X14, X12
P F81FF0AF STUR X15, [X5, #-1]
S st_neg_offset 4 10 30 - 14
P 8B010030 ADD  X16, X1, X1
P 8A020071 AND  X17, X3, X2
P AA080212 ORR  X18, X16, X8
P F80000D2 STUR X18, [X6, #0]
S st_orr_wb_fwd 6 A 2 | 8
P F80010F1 STUR X17, [X7, #1]
S st_and_write_thru 8 2 3 & 2

// ==== sim/tb_legv8_core.sv ====
`timescale 1ns/100ps

module tb_legv8_core;

	localparam int MAX_PROG     = 64;
	localparam int MAX_STORE    = 32;
	localparam int MEM_WORDS    = 32;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 4; // Last instruction through EX, MEM, WB
	localparam int QUIET_CYCLES = 8;

	logic                             CLOCK = 1'b1;
	logic                             rst_n;
	logic [legv8_pkg::INSTR_W-1:0]    instr;
	logic [legv8_pkg::DATA_W-1:0]     mem_rdata;
	logic [legv8_pkg::DATA_W-1:0]     pc;
	logic [legv8_pkg::DATA_W-1:0]     mem_addr;
	logic [legv8_pkg::DATA_W-1:0]     mem_wdata;
	logic                             mem_write;
	logic                             mem_read;

	logic [legv8_pkg::INSTR_W-1:0]    prog [MAX_PROG];
	logic [legv8_pkg::DATA_W-1:0]     dmem [MEM_WORDS];
	logic [8*24-1:0]                  st_name [MAX_STORE];
	logic [legv8_pkg::DATA_W-1:0]     st_addr [MAX_STORE];
	logic [legv8_pkg::DATA_W-1:0]     st_data [MAX_STORE];

	int prog_len = 0;
	int st_count = 0;
	int st_seen = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit vec_ok;

	always #50 CLOCK = ~CLOCK;

	legv8_core legv8_core_inst (
		.CLOCK     (CLOCK),
		.rst_n     (rst_n),
		.instr     (instr),
		.mem_rdata (mem_rdata),
		.pc        (pc),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_write (mem_write),
		.mem_read  (mem_read)
	);

	// Instruction ROM, zero words past the program
	assign instr = ((pc >> 2) < 64'(prog_len)) ? prog[pc[7:2]] : '0;
	assign mem_rdata = mem_read ? dmem[mem_addr[4:0]] : '0;

	always @(posedge CLOCK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				dmem[i] <= 64'(5 * i);
		end
		else if (mem_write)
			dmem[mem_addr[4:0]] <= mem_wdata;
	end

	always @(posedge CLOCK)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout: the program did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(negedge CLOCK)
	begin
		if (rst_n && mem_write)
			check_store();
	end

	task automatic read_vectors(output bit ok);
		int fd;
		int code;
		logic [8*8-1:0]               tag;
		logic [8*128-1:0]             rest;
		logic [legv8_pkg::INSTR_W-1:0] word;
		logic [8*24-1:0]              name;
		logic [legv8_pkg::DATA_W-1:0] addr;
		logic [legv8_pkg::DATA_W-1:0] data;
		ok = 1'b1;
		fd = $fopen("sim/legv8_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open sim/legv8_vectors.txt");
			ok = 1'b0;
		end
		else
		begin
			code = $fscanf(fd, "%s", tag);
			while (code == 1 && ok)
			begin
				if (tag == 64'("P") && prog_len < MAX_PROG)
				begin
					code = $fscanf(fd, "%h", word);
					prog[prog_len] = word;
					prog_len++;
					ok = (code == 1);
				end
				else if (tag == 64'("S") && st_count < MAX_STORE)
				begin
					code = $fscanf(fd, "%s %h %h", name, addr, data);
					st_name[st_count] = name;
					st_addr[st_count] = addr;
					st_data[st_count] = data;
					st_count++;
					ok = (code == 3);
				end
				else if (tag != 64'("#"))
					ok = 1'b0;
				if (!ok)
					$display("Vector file has a bad or surplus line, tag %0s", tag);
				code = $fgets(rest, fd); // Rest of line is a note
				code = $fscanf(fd, "%s", tag);
			end
			$fclose(fd);
		end
	endtask

	// Index of the first LDUR word, or -1
	function automatic int find_load(int n);
		int idx;
		idx = -1;
		for (int i = 0; i < n; i++)
			if (idx < 0 && prog[i][31:21] == 11'b11111000010)
				idx = i;
		return idx;
	endfunction

	task automatic check_store();
		if (st_seen >= st_count)
			$display("Store number %0d is not in the vector file, address %0h data %0h",
				st_seen + 1, mem_addr, mem_wdata);
		else
		begin
			tests_run++;
			if (mem_addr !== st_addr[st_seen])
			begin
				tests_failed++;
				$display("** Error %0s: address expected %0h actual %0h",
					st_name[st_seen], st_addr[st_seen], mem_addr);
			end
			else if (mem_wdata !== st_data[st_seen])
			begin
				tests_failed++;
				$display("** Error %0s: data expected %0h actual %0h",
					st_name[st_seen], st_data[st_seen], mem_wdata);
			end
			else
				$display("ok    %0s: address %0h data %0h", st_name[st_seen], mem_addr, mem_wdata);
		end
		st_seen++;
	endtask

	task automatic run_program();
		int load_idx;
		int repeats;
		int late_stores;
		bit reset_ok;
		logic [legv8_pkg::DATA_W-1:0] prev_pc;
		logic [legv8_pkg::DATA_W-1:0] repeat_pc;
		logic [legv8_pkg::DATA_W-1:0] end_pc;
		load_idx = find_load(prog_len);
		repeats = 0;
		late_stores = 0;
		reset_ok = 1'b1;
		repeat_pc = '0;
		end_pc = 64'(prog_len * 4);

		@(negedge CLOCK);
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
		begin
			@(negedge CLOCK);
			if (pc != '0 || mem_write || mem_read)
				reset_ok = 1'b0;
		end
		tests_run++;
		if (!reset_ok)
		begin
			tests_failed++;
			$display("** Error reset_state: expected pc 0 wr 0 rd 0 actual pc %0h wr %b rd %b",
				pc, mem_write, mem_read);
		end
		else
			$display("ok    reset_state: pc 0, no memory access");

		// Pc stays zero until the first edge after release, then steps once
		rst_n = 1'b1;
		@(negedge CLOCK);
		tests_run++;
		if (pc != 64'd4 || mem_write || mem_read)
		begin
			tests_failed++;
			$display("** Error reset_release: expected pc 4 wr 0 rd 0 actual pc %0h wr %b rd %b",
				pc, mem_write, mem_read);
		end
		else
			$display("ok    reset_release: pc left zero on the first edge");

		prev_pc = pc;
		while (pc < end_pc)
		begin
			@(negedge CLOCK);
			if (pc == prev_pc)
			begin
				repeats++;
				repeat_pc = pc;
			end
			prev_pc = pc;
		end
		repeat (DRAIN_CYCLES) @(negedge CLOCK);
		repeat (QUIET_CYCLES)
		begin
			@(negedge CLOCK);
			if (mem_write)
				late_stores++;
		end

		tests_run++;
		if (load_idx < 0)
		begin
			tests_failed++;
			$display("load_use_stall: the program holds no LDUR");
		end
		else if (repeats != 1)
		begin
			tests_failed++;
			$display("** Error load_use_stall: held pc count expected 1 actual %0d", repeats);
		end
		else if (repeat_pc != 64'((load_idx + 2) * 4))
		begin
			tests_failed++;
			$display("** Error load_use_stall: held pc expected %0h actual %0h",
				64'((load_idx + 2) * 4), repeat_pc);
		end
		else
			$display("ok    load_use_stall: pc %0h held one cycle", repeat_pc);

		tests_run++;
		if (st_seen != st_count)
		begin
			tests_failed++;
			$display("** Error completeness: stores expected %0d actual %0d", st_count, st_seen);
		end
		else if (late_stores != 0)
		begin
			tests_failed++;
			$display("completeness: a store happened after the pipeline drained");
		end
		else
			$display("ok    completeness: %0d stores", st_seen);
	endtask

	initial
	begin
		rst_n = 1'b1;
		read_vectors(vec_ok);
		if (!vec_ok)
		begin
			$display("No tests run, the vector file could not be used");
			$display("SIMULATION FAILED");
		end
		else
		begin
			cycle_limit = 4 * (prog_len + 10);
			run_program();
			$display("Tests: %0d run, %0d passed, %0d failed",
				tests_run, tests_run - tests_failed, tests_failed);
			if (tests_failed == 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/legv8_core.sv ====
`timescale 1ns/100ps

module legv8_core (
	input  logic                             CLOCK,
	input  logic                             rst_n,
	input  logic [legv8_pkg::INSTR_W-1:0]    instr,
	input  logic [legv8_pkg::DATA_W-1:0]     mem_rdata,
	output logic [legv8_pkg::DATA_W-1:0]     pc,
	output logic [legv8_pkg::DATA_W-1:0]     mem_addr,
	output logic [legv8_pkg::DATA_W-1:0]     mem_wdata,
	output logic                             mem_write,
	output logic                             mem_read
);

	// ID/EX
	logic [3:0]                        ex_alu_ctrl;
	logic                              ex_alu_src;
	logic                              ex_mem_read;
	logic                              ex_mem_write;
	logic                              ex_reg_write;
	logic                              ex_mem_to_reg;
	logic [legv8_pkg::DATA_W-1:0]      ex_rn_data;
	logic [legv8_pkg::DATA_W-1:0]      ex_rm_data;
	logic [legv8_pkg::DATA_W-1:0]      ex_imm;
	logic [legv8_pkg::REG_ADDR_W-1:0]  ex_rn;
	logic [legv8_pkg::REG_ADDR_W-1:0]  ex_rm;
	logic [legv8_pkg::REG_ADDR_W-1:0]  ex_rd;

	// EX/MEM
	logic [legv8_pkg::REG_ADDR_W-1:0]  mem_rd;
	logic                              mem_reg_write;
	logic                              mem_to_reg;

	// MEM/WB
	logic [legv8_pkg::REG_ADDR_W-1:0]  wb_rd;
	logic                              wb_reg_write;
	logic [legv8_pkg::DATA_W-1:0]      wb_data;

	decode_stage decode_stage_inst (
		.CLOCK         (CLOCK),
		.rst_n         (rst_n),
		.instr         (instr),
		.wb_rd         (wb_rd),
		.wb_reg_write  (wb_reg_write),
		.wb_data       (wb_data),
		.pc            (pc),
		.ex_alu_ctrl   (ex_alu_ctrl),
		.ex_alu_src    (ex_alu_src),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_to_reg (ex_mem_to_reg),
		.ex_rn_data    (ex_rn_data),
		.ex_rm_data    (ex_rm_data),
		.ex_imm        (ex_imm),
		.ex_rn         (ex_rn),
		.ex_rm         (ex_rm),
		.ex_rd         (ex_rd)
	);

	execute_stage execute_stage_inst (
		.CLOCK         (CLOCK),
		.rst_n         (rst_n),
		.ex_alu_ctrl   (ex_alu_ctrl),
		.ex_alu_src    (ex_alu_src),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_to_reg (ex_mem_to_reg),
		.ex_rn_data    (ex_rn_data),
		.ex_rm_data    (ex_rm_data),
		.ex_imm        (ex_imm),
		.ex_rn         (ex_rn),
		.ex_rm         (ex_rm),
		.ex_rd         (ex_rd),
		.wb_rd         (wb_rd),
		.wb_reg_write  (wb_reg_write),
		.wb_data       (wb_data),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_write     (mem_write),
		.mem_read      (mem_read),
		.mem_rd        (mem_rd),
		.mem_reg_write (mem_reg_write),
		.mem_to_reg    (mem_to_reg)
	);

	mem_writeback mem_writeback_inst (
		.CLOCK         (CLOCK),
		.rst_n         (rst_n),
		.mem_addr      (mem_addr),
		.mem_rdata     (mem_rdata),
		.mem_rd        (mem_rd),
		.mem_reg_write (mem_reg_write),
		.mem_to_reg    (mem_to_reg),
		.wb_rd         (wb_rd),
		.wb_reg_write  (wb_reg_write),
		.wb_data       (wb_data)
	);

endmodule

// ==== hw/mem_writeback.sv ====
`timescale 1ns/100ps

module mem_writeback (
	input  logic                             CLOCK,
	input  logic                             rst_n,
	input  logic [legv8_pkg::DATA_W-1:0]     mem_addr,
	input  logic [legv8_pkg::DATA_W-1:0]     mem_rdata,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic                             mem_reg_write,
	input  logic                             mem_to_reg,
	output logic [legv8_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic                             wb_reg_write,
	output logic [legv8_pkg::DATA_W-1:0]     wb_data
);

	logic                         wb_mem_to_reg;
	logic [legv8_pkg::DATA_W-1:0] wb_alu;
	logic [legv8_pkg::DATA_W-1:0] wb_load;

	always_ff @(posedge CLOCK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_reg_write <= 1'b0;
			wb_mem_to_reg <= 1'b0;
			wb_rd <= '0;
		end
		else
		begin
			wb_reg_write <= mem_reg_write;
			wb_mem_to_reg <= mem_to_reg;
			wb_rd <= mem_rd;
		end
	end

	always_ff @(posedge CLOCK)
	begin
		wb_alu <= mem_addr;
		wb_load <= mem_rdata;
	end

	assign wb_data = wb_mem_to_reg ? wb_load : wb_alu; // Loads take memory data

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
	input  logic                             CLOCK,
	input  logic                             rst_n,
	input  logic [3:0]                       ex_alu_ctrl,
	input  logic                             ex_alu_src,
	input  logic                             ex_mem_read,
	input  logic                             ex_mem_write,
	input  logic                             ex_reg_write,
	input  logic                             ex_mem_to_reg,
	input  logic [legv8_pkg::DATA_W-1:0]     ex_rn_data,
	input  logic [legv8_pkg::DATA_W-1:0]     ex_rm_data,
	input  logic [legv8_pkg::DATA_W-1:0]     ex_imm,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] ex_rn,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] ex_rm,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] ex_rd,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic                             wb_reg_write,
	input  logic [legv8_pkg::DATA_W-1:0]     wb_data,
	output logic [legv8_pkg::DATA_W-1:0]     mem_addr,
	output logic [legv8_pkg::DATA_W-1:0]     mem_wdata,
	output logic                             mem_write,
	output logic                             mem_read,
	output logic [legv8_pkg::REG_ADDR_W-1:0] mem_rd,
	output logic                             mem_reg_write,
	output logic                             mem_to_reg
);

	logic [1:0]                   fwd_a;
	logic [1:0]                   fwd_b;
	logic [legv8_pkg::DATA_W-1:0] op_a;
	logic [legv8_pkg::DATA_W-1:0] op_b_reg;
	logic [legv8_pkg::DATA_W-1:0] op_b;
	logic [legv8_pkg::DATA_W-1:0] alu_result;

	function automatic logic [legv8_pkg::DATA_W-1:0] pick_operand(
		input logic [1:0]                   sel,
		input logic [legv8_pkg::DATA_W-1:0] reg_val);
		case (sel)
			legv8_pkg::FWD_MEM: return mem_addr; // ALU result held in EX/MEM
			legv8_pkg::FWD_WB:  return wb_data;
			default:            return reg_val;
		endcase
	endfunction

	forwarding_unit forwarding_unit_inst (
		.ex_rn         (ex_rn),
		.ex_rm         (ex_rm),
		.mem_rd        (mem_rd),
		.mem_reg_write (mem_reg_write),
		.wb_rd         (wb_rd),
		.wb_reg_write  (wb_reg_write),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b)
	);

	always_comb
	begin
		op_a = pick_operand(fwd_a, ex_rn_data);
		op_b_reg = pick_operand(fwd_b, ex_rm_data);
		op_b = ex_alu_src ? ex_imm : op_b_reg;
	end

	alu alu_inst (
		.a        (op_a),
		.b        (op_b),
		.alu_ctrl (ex_alu_ctrl),
		.result   (alu_result)
	);

	always_ff @(posedge CLOCK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_write <= 1'b0;
			mem_read <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_to_reg <= 1'b0;
			mem_rd <= '0;
		end
		else
		begin
			mem_write <= ex_mem_write;
			mem_read <= ex_mem_read;
			mem_reg_write <= ex_reg_write;
			mem_to_reg <= ex_mem_to_reg;
			mem_rd <= ex_rd;
		end
	end

	always_ff @(posedge CLOCK)
	begin
		mem_addr <= alu_result;
		mem_wdata <= op_b_reg; // Store data after forwarding
	end

	a_no_read_write: assert property (@(posedge CLOCK) disable iff (!rst_n)
		!(mem_write && mem_read));

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
	input  logic                             CLOCK,
	input  logic                             rst_n,
	input  logic [legv8_pkg::INSTR_W-1:0]    instr,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic                             wb_reg_write,
	input  logic [legv8_pkg::DATA_W-1:0]     wb_data,
	output logic [legv8_pkg::DATA_W-1:0]     pc,
	output logic [3:0]                       ex_alu_ctrl,
	output logic                             ex_alu_src,
	output logic                             ex_mem_read,
	output logic                             ex_mem_write,
	output logic                             ex_reg_write,
	output logic                             ex_mem_to_reg,
	output logic [legv8_pkg::DATA_W-1:0]     ex_rn_data,
	output logic [legv8_pkg::DATA_W-1:0]     ex_rm_data,
	output logic [legv8_pkg::DATA_W-1:0]     ex_imm,
	output logic [legv8_pkg::REG_ADDR_W-1:0] ex_rn,
	output logic [legv8_pkg::REG_ADDR_W-1:0] ex_rm,
	output logic [legv8_pkg::REG_ADDR_W-1:0] ex_rd
);

	legv8_pkg::instr_t                if_id_instr;
	logic [3:0]                       id_alu_ctrl;
	logic                             id_alu_src;
	logic                             id_mem_read;
	logic                             id_mem_write;
	logic                             id_reg_write;
	logic                             id_mem_to_reg;
	logic [legv8_pkg::REG_ADDR_W-1:0] id_rb;
	logic [legv8_pkg::DATA_W-1:0]     id_rn_data;
	logic [legv8_pkg::DATA_W-1:0]     id_rb_data;
	logic                             uses_b;
	logic                             stall;

	always_ff @(posedge CLOCK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= '0;
			if_id_instr <= '0; // Zero word decodes as a bubble
		end
		else if (!stall)
		begin
			pc <= pc + legv8_pkg::DATA_W'(legv8_pkg::PC_STEP);
			if_id_instr <= instr;
		end
	end

	always_comb
	begin
		id_alu_ctrl = legv8_pkg::ALU_AND;
		id_alu_src = 1'b0;
		id_mem_read = 1'b0;
		id_mem_write = 1'b0;
		id_reg_write = 1'b0;
		id_mem_to_reg = 1'b0;
		case (if_id_instr.r.opcode)
			legv8_pkg::OP_LDUR:
			begin
				id_alu_ctrl = legv8_pkg::ALU_ADD;
				id_alu_src = 1'b1;
				id_mem_read = 1'b1;
				id_reg_write = 1'b1;
				id_mem_to_reg = 1'b1;
			end
			legv8_pkg::OP_STUR:
			begin
				id_alu_ctrl = legv8_pkg::ALU_ADD;
				id_alu_src = 1'b1;
				id_mem_write = 1'b1;
			end
			legv8_pkg::OP_ADD:
			begin
				id_alu_ctrl = legv8_pkg::ALU_ADD;
				id_reg_write = 1'b1;
			end
			legv8_pkg::OP_SUB:
			begin
				id_alu_ctrl = legv8_pkg::ALU_SUB;
				id_reg_write = 1'b1;
			end
			legv8_pkg::OP_AND:
				id_reg_write = 1'b1; // ALU_AND already set
			legv8_pkg::OP_ORR:
			begin
				id_alu_ctrl = legv8_pkg::ALU_ORR;
				id_reg_write = 1'b1;
			end
			default: ;
		endcase
	end

	// STUR reads rt as its second operand
	assign id_rb = id_mem_write ? if_id_instr.d.rt : if_id_instr.r.rm;
	assign uses_b = id_mem_write | (id_reg_write & ~id_alu_src);

	// Load-use hazard against the load now in EX
	assign stall = ex_mem_read && (id_reg_write || id_mem_write) &&
		((ex_rd == if_id_instr.r.rn) || (uses_b && (ex_rd == id_rb)));

	reg_file reg_file_inst (
		.CLOCK     (CLOCK),
		.rst_n     (rst_n),
		.rd_addr_a (if_id_instr.r.rn),
		.rd_addr_b (id_rb),
		.wr_addr   (wb_rd),
		.wr_data   (wb_data),
		.wr_en     (wb_reg_write),
		.rd_data_a (id_rn_data),
		.rd_data_b (id_rb_data)
	);

	always_ff @(posedge CLOCK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_alu_ctrl <= legv8_pkg::ALU_AND;
			ex_alu_src <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_to_reg <= 1'b0;
		end
		else
		begin
			ex_alu_ctrl <= stall ? legv8_pkg::ALU_AND : id_alu_ctrl;
			ex_alu_src <= id_alu_src & ~stall;
			ex_mem_read <= id_mem_read & ~stall;
			ex_mem_write <= id_mem_write & ~stall;
			ex_reg_write <= id_reg_write & ~stall;
			ex_mem_to_reg <= id_mem_to_reg & ~stall;
		end
	end

	always_ff @(posedge CLOCK)
	begin
		ex_rn_data <= id_rn_data;
		ex_rm_data <= id_rb_data;
		ex_imm <= {{(legv8_pkg::DATA_W-9){if_id_instr.d.addr[8]}}, if_id_instr.d.addr};
		ex_rn <= if_id_instr.r.rn;
		ex_rm <= id_rb;
		ex_rd <= if_id_instr.r.rd;
	end

	// Stall only behind a load that writes its register
	a_stall_on_load: assert property (@(posedge CLOCK) disable iff (!rst_n)
		stall |-> (ex_reg_write && ex_mem_to_reg && !ex_mem_write));

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
	input  logic                             CLOCK,
	input  logic                             rst_n,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] rd_addr_a,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] rd_addr_b,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [legv8_pkg::DATA_W-1:0]     wr_data,
	input  logic                             wr_en,
	output logic [legv8_pkg::DATA_W-1:0]     rd_data_a,
	output logic [legv8_pkg::DATA_W-1:0]     rd_data_b
);

	logic [legv8_pkg::DATA_W-1:0] regs [legv8_pkg::NUM_REGS];

	function automatic logic [legv8_pkg::DATA_W-1:0] read_port(
		input logic [legv8_pkg::REG_ADDR_W-1:0] addr);
		if (addr == legv8_pkg::XZR)
			return '0;
		if (wr_en && (wr_addr == addr))
			return wr_data; // Write-through from WB
		return regs[addr];
	endfunction

	always_ff @(posedge CLOCK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < legv8_pkg::NUM_REGS; i++)
				regs[i] <= legv8_pkg::DATA_W'(i);
		end
		else if (wr_en && (wr_addr != legv8_pkg::XZR))
			regs[wr_addr] <= wr_data;
	end

	always_comb
	begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
	end

endmodule

// ==== hw/forwarding_unit.sv ====
`timescale 1ns/100ps

module forwarding_unit (
	input  logic [legv8_pkg::REG_ADDR_W-1:0] ex_rn,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] ex_rm,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic                             mem_reg_write,
	input  logic [legv8_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic                             wb_reg_write,
	output logic [1:0]                       fwd_a,
	output logic [1:0]                       fwd_b
);

	// Newest producer wins, XZR never forwards
	function automatic logic [1:0] pick_src(
		input logic [legv8_pkg::REG_ADDR_W-1:0] src);
		if (mem_reg_write && (mem_rd != legv8_pkg::XZR) && (mem_rd == src))
			return legv8_pkg::FWD_MEM;
		if (wb_reg_write && (wb_rd != legv8_pkg::XZR) && (wb_rd == src))
			return legv8_pkg::FWD_WB;
		return legv8_pkg::FWD_REG;
	endfunction

	always_comb
	begin
		fwd_a = pick_src(ex_rn);
		fwd_b = pick_src(ex_rm);
	end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
	input  logic [legv8_pkg::DATA_W-1:0] a,
	input  logic [legv8_pkg::DATA_W-1:0] b,
	input  logic [3:0]                   alu_ctrl,
	output logic [legv8_pkg::DATA_W-1:0] result
);

	always_comb
	begin
		case (alu_ctrl)
			legv8_pkg::ALU_AND: result = a & b;
			legv8_pkg::ALU_ORR: result = a | b;
			legv8_pkg::ALU_ADD: result = a + b;
			legv8_pkg::ALU_SUB: result = a - b;
			default:            result = '0;
		endcase
	end

	// Decode only ever emits the four codes, bubbles included
	always_comb
	begin
		a_ctrl_known: assert (alu_ctrl inside {legv8_pkg::ALU_AND, legv8_pkg::ALU_ORR,
			legv8_pkg::ALU_ADD, legv8_pkg::ALU_SUB})
		else
			$error("unknown ALU control %b", alu_ctrl);
	end

endmodule

// ==== hw/legv8_pkg.sv ====
package legv8_pkg;

	localparam int DATA_W     = 64;
	localparam int INSTR_W    = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int PC_STEP    = 4;

	localparam logic [REG_ADDR_W-1:0] XZR = 5'd31;

	// Opcode field, bits 31:21
	localparam logic [10:0] OP_LDUR = 11'b11111000010;
	localparam logic [10:0] OP_STUR = 11'b11111000000;
	localparam logic [10:0] OP_ADD  = 11'b10001011000;
	localparam logic [10:0] OP_SUB  = 11'b11001011000;
	localparam logic [10:0] OP_AND  = 11'b10001010000;
	localparam logic [10:0] OP_ORR  = 11'b10101010000;

	localparam logic [3:0] ALU_AND = 4'b0000;
	localparam logic [3:0] ALU_ORR = 4'b0001;
	localparam logic [3:0] ALU_ADD = 4'b0010;
	localparam logic [3:0] ALU_SUB = 4'b0110;

	// Operand source for the ALU inputs
	localparam logic [1:0] FWD_REG = 2'b00;
	localparam logic [1:0] FWD_WB  = 2'b01;
	localparam logic [1:0] FWD_MEM = 2'b10;

	typedef struct packed
	{
		logic [10:0]           opcode;
		logic [REG_ADDR_W-1:0] rm;
		logic [5:0]            shamt;
		logic [REG_ADDR_W-1:0] rn;
		logic [REG_ADDR_W-1:0] rd;
	} r_fmt_t;

	typedef struct packed
	{
		logic [10:0]           opcode;
		logic [8:0]            addr; // Signed byte offset
		logic [1:0]            op2;
		logic [REG_ADDR_W-1:0] rn;
		logic [REG_ADDR_W-1:0] rt;
	} d_fmt_t;

	typedef union packed
	{
		r_fmt_t r;
		d_fmt_t d;
	} instr_t;

endpackage
